// File: list.f
+incdir+design
design/wb_pkg.sv
design/timer_pkg.sv
design/timer_channel.sv
design/timer_irq.sv
design/timer_wb_regs.sv
design/timer_subsystem.sv
tb/tb_timer_subsystem.sv

// File: tb/tb_timer_subsystem.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module tb_timer_subsystem import wb_pkg::*;;

    typedef struct packed {
        int unsigned high;   // cycles pwm is high per period
        int unsigned period; // cycles per period
    } pwm_exp_t;

    logic clk;
    logic rst_n;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic [`TIMER_CHANNELS-1:0] pwm;
    logic irq;

    int err_data, err_timing, err_flag, err_other;
    int cycles;
    logic [31:0] lcg_state = 32'h40f4f897;

    // monitor state, one entry per channel
    logic prev_pwm [`TIMER_CHANNELS];
    logic seen_rise [`TIMER_CHANNELS];
    int hi_run [`TIMER_CHANNELS];
    int len_run [`TIMER_CHANNELS];
    int hi_meas [`TIMER_CHANNELS];
    int per_meas [`TIMER_CHANNELS];
    int meas_n [`TIMER_CHANNELS];

    timer_subsystem dut (.clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp),
                         .pwm(pwm), .irq(irq));

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    // run limit, worst case period sum times four
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 20000) begin
            $display("timeout: run did not finish within 20000 cycles");
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // pwm measured rising edge to rising edge, sampled mid cycle
    always @(negedge clk) begin
        for (int c = 0; c < `TIMER_CHANNELS; c++) begin
            if (!rst_n) begin
                prev_pwm[c]  = 1'b0;
                seen_rise[c] = 1'b0;
                hi_run[c]    = 0;
                len_run[c]   = 0;
                meas_n[c]    = 0;
            end else if (pwm[c] && !prev_pwm[c]) begin
                if (seen_rise[c]) begin // a full period just closed
                    hi_meas[c]  = hi_run[c];
                    per_meas[c] = len_run[c];
                    meas_n[c]++;
                end
                seen_rise[c] = 1'b1;
                hi_run[c]    = 1;
                len_run[c]   = 1;
            end else begin
                len_run[c]++;
                if (pwm[c]) hi_run[c]++;
            end
            prev_pwm[c] = pwm[c];
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 16; // upper bits have the longer cycle
    endfunction

    function automatic pwm_exp_t pwm_expect(input int p, input int t, input int m);
        pwm_exp_t e;
        e.period = (t + 1) * (p + 1);
        e.high   = (m >= t) ? e.period : (m + 1) * (p + 1); // cmp at or over top stays high
        return e;
    endfunction

    function automatic logic [`WB_ADDR_BITS-1:0] reg_addr(input int c, input int ofs);
        return c * `TIMER_CH_STRIDE + ofs;
    endfunction

    task automatic check_data(input string name, input logic [`WB_DATA_BITS-1:0] exp,
                              input logic [`WB_DATA_BITS-1:0] act);
        if (act !== exp) begin
            err_data++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_timing(input string name, input int exp, input int act);
        if (act != exp) begin
            err_timing++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_flag++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // one classic cycle, held until ack
    task automatic wb_xfer(input logic we, input logic [`WB_ADDR_BITS-1:0] adr,
                           input logic [`WB_DATA_BITS-1:0] wdat,
                           output logic [`WB_DATA_BITS-1:0] rdat);
        int n;
        @(posedge clk);
        #1;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdat;
        wb_req.sel   = '1;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_rsp.ack && n < 8);
        if (!wb_rsp.ack) begin
            err_other++;
            $display("no ack from address %h within 8 cycles", adr);
        end
        rdat = wb_rsp.dat_r; // valid while ack is high
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`WB_ADDR_BITS-1:0] adr,
                            input logic [`WB_DATA_BITS-1:0] dat);
        logic [`WB_DATA_BITS-1:0] unused;
        wb_xfer(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [`WB_ADDR_BITS-1:0] adr,
                           output logic [`WB_DATA_BITS-1:0] dat);
        wb_xfer(1'b0, adr, '0, dat);
    endtask

    task automatic wait_meas(input int c, input int n, input int limit);
        int start;
        int k;
        start = meas_n[c];
        k = 0;
        while (meas_n[c] < start + n && k < limit) begin
            @(posedge clk);
            k++;
        end
        if (meas_n[c] < start + n) begin
            err_other++;
            $display("channel %0d produced no complete pwm period in time", c);
        end
    endtask

    // stop, load and restart, so no relatch is involved
    task automatic start_channel(input int c, input int p, input int t, input int m);
        wb_write(reg_addr(c, `REG_CTRL), 0);
        wb_write(reg_addr(c, `REG_PRESC), p);
        wb_write(reg_addr(c, `REG_TOP), t);
        wb_write(reg_addr(c, `REG_CMP), m);
        wb_write(reg_addr(c, `REG_CTRL), 1);
    endtask

    task automatic check_pwm(input int c, input int p, input int t, input int m);
        pwm_exp_t e;
        logic all_high;
        e = pwm_expect(p, t, m);
        if (e.high == e.period) begin
            all_high = 1'b1;
            repeat (2) @(posedge clk);
            repeat (2 * e.period) begin
                @(negedge clk);
                all_high &= pwm[c];
            end
            check_flag("pwm always high", 1'b1, all_high);
        end else begin
            wait_meas(c, 2, 4 * e.period + 40); // skip the partial first period
            check_timing("pwm period", e.period, per_meas[c]);
            check_timing("pwm high", e.high, hi_meas[c]);
        end
    endtask

    initial begin
        logic [`WB_DATA_BITS-1:0] rd, rd2;
        int p, t, m, n;
        logic irq_seen;
        wb_req = '0;
        rst_n  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // register readback on both channels
        for (int c = 0; c < `TIMER_CHANNELS; c++) begin
            wb_write(reg_addr(c, `REG_PRESC), 32'h5a + c);
            wb_write(reg_addr(c, `REG_TOP), 32'h1234 + c);
            wb_write(reg_addr(c, `REG_CMP), 32'hbeef - c);
            wb_write(reg_addr(c, `REG_CTRL), 1);
            wb_read(reg_addr(c, `REG_PRESC), rd);
            check_data("presc", 32'h5a + c, rd);
            wb_read(reg_addr(c, `REG_TOP), rd);
            check_data("top", 32'h1234 + c, rd);
            wb_read(reg_addr(c, `REG_CMP), rd);
            check_data("cmp", 32'hbeef - c, rd);
            wb_read(reg_addr(c, `REG_CTRL), rd);
            check_data("ctrl", 32'h1, rd);
            wb_write(reg_addr(c, `REG_CTRL), 0);
        end
        wb_read(8'h14, rd);
        check_data("unmapped 0x14", '0, rd);
        wb_read(8'h40, rd);
        check_data("unmapped 0x40", '0, rd);
        wb_read(8'h88, rd);
        check_data("unmapped 0x88", '0, rd);

        // random duty and period per channel
        repeat (3) begin
            for (int c = 0; c < `TIMER_CHANNELS; c++) begin
                p = lcg_next() % 4;
                t = 2 + lcg_next() % 8;
                m = lcg_next() % (t + 2);
                start_channel(c, p, t, m);
                check_pwm(c, p, t, m);
            end
        end

        // cmp above top keeps pwm high
        start_channel(0, 1, 3, 4);
        check_pwm(0, 1, 3, 4);

        // relatch on ch0 while ch1 keeps its waveform
        start_channel(0, 1, 5, 1);
        start_channel(1, 2, 4, 2);
        check_pwm(0, 1, 5, 1);
        check_pwm(1, 2, 4, 2);
        wb_write(reg_addr(0, `REG_CMP), 3);
        wait_meas(0, 3, 80);
        check_timing("pwm high after relatch", 8, hi_meas[0]);
        check_timing("pwm period after relatch", 12, per_meas[0]);
        check_pwm(1, 2, 4, 2);

        // count bounds, then stop
        repeat (6) begin
            wb_read(reg_addr(0, `REG_COUNT), rd);
            check_flag("count at most top", 1'b1, rd <= 5);
        end
        wb_write(reg_addr(0, `REG_CTRL), 0);
        repeat (2) @(posedge clk);
        #1;
        check_flag("pwm after stop", 1'b0, pwm[0]);
        wb_read(reg_addr(0, `REG_COUNT), rd);
        repeat (10) @(posedge clk);
        wb_read(reg_addr(0, `REG_COUNT), rd2);
        check_data("frozen count", rd, rd2);

        // enabled interrupt on ch1, period 15
        wb_write(`REG_IRQ_STATUS, 32'h3); // drop the bits the earlier runs left set
        wb_write(`REG_IRQ_ENABLE, 32'h2);
        n = 0;
        while (!irq && n < 15 + 2) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_flag("irq", 1'b1, irq);
        wb_read(`REG_IRQ_STATUS, rd);
        check_data("irq status", 32'h2, rd);
        wb_write(reg_addr(1, `REG_CTRL), 0);
        repeat (2) @(posedge clk);
        wb_write(`REG_IRQ_STATUS, 32'h2);
        wb_read(`REG_IRQ_STATUS, rd);
        check_data("irq status after clear", '0, rd);
        check_flag("irq after clear", 1'b0, irq);

        // masked channel still sets status, irq stays low
        wb_write(`REG_IRQ_ENABLE, 32'h0);
        wb_write(reg_addr(1, `REG_CTRL), 1);
        irq_seen = 1'b0;
        repeat (15 + 4) begin
            @(posedge clk);
            #1;
            irq_seen |= irq;
        end
        check_flag("irq while masked", 1'b0, irq_seen);
        wb_read(`REG_IRQ_STATUS, rd);
        check_data("masked irq status", 32'h2, rd);

        $display("errors: data %0d timing %0d flag %0d other %0d",
                 err_data, err_timing, err_flag, err_other);
        if (err_data + err_timing + err_flag + err_other == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: design/timer_subsystem.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module timer_subsystem import wb_pkg::*, timer_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  wb_req_t                    wb_req,
    output wb_rsp_t                    wb_rsp,
    output logic [`TIMER_CHANNELS-1:0] pwm,
    output logic                       irq
);

    timer_cfg_t  [`TIMER_CHANNELS-1:0] cfg;        // register file to channels
    timer_stat_t [`TIMER_CHANNELS-1:0] stat;       // channels back to the register file
    irq_ctl_t                          irq_ctl;
    logic        [`TIMER_CHANNELS-1:0] irq_status;
    logic        [`TIMER_CHANNELS-1:0] irq_enable;
    logic        [`TIMER_CHANNELS-1:0] period_end;

    // bus slave and parameter registers
    timer_wb_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .cfg        (cfg),
        .stat       (stat),
        .irq_ctl    (irq_ctl),
        .irq_status (irq_status),
        .irq_enable (irq_enable)
    );

    for (genvar c = 0; c < `TIMER_CHANNELS; c++) begin : g_ch
        timer_channel u_ch (
            .clk   (clk),
            .rst_n (rst_n),
            .cfg   (cfg[c]),
            .stat  (stat[c])
        );

        assign pwm[c]        = stat[c].pwm;
        assign period_end[c] = stat[c].period_end; // bypasses the register file
    end

    // sticky status and interrupt line
    timer_irq u_irq (
        .clk        (clk),
        .rst_n      (rst_n),
        .period_end (period_end),
        .ctl        (irq_ctl),
        .status     (irq_status),
        .enable     (irq_enable),
        .irq        (irq)
    );

endmodule

// File: design/timer_wb_regs.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module timer_wb_regs import wb_pkg::*, timer_pkg::*; (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  wb_req_t                                 wb_req,
    output wb_rsp_t                                 wb_rsp,
    output timer_cfg_t  [`TIMER_CHANNELS-1:0]       cfg,
    input  timer_stat_t [`TIMER_CHANNELS-1:0]       stat,
    output irq_ctl_t                                irq_ctl,
    input  logic        [`TIMER_CHANNELS-1:0]       irq_status,
    input  logic        [`TIMER_CHANNELS-1:0]       irq_enable
);

    localparam int OFS_BITS = $clog2(`TIMER_CH_STRIDE);   // offset inside a channel block
    localparam int CH_BITS  = `WB_ADDR_BITS - OFS_BITS;   // channel field of the address

    logic                     ack_q;     // ack to the master
    logic                     hold_q;    // strobe still high after an ack
    logic                     req_valid; // new transfer accepted this cycle
    logic                     wr_en;
    logic [CH_BITS-1:0]       ch_field;
    logic [OFS_BITS-1:0]      ofs;
    logic                     ch_hit;    // address falls in a channel block
    logic [`WB_DATA_BITS-1:0] rd_data;
    logic [`WB_DATA_BITS-1:0] dat_r_q;

    logic [`TIMER_CHANNELS-1:0] go_q;
    logic [`TIMER_CHANNELS-1:0] rl_arm;    // parameter write to a running channel
    logic [`TIMER_CHANNELS-1:0] relatch_q; // one cycle after the ack
    logic [`TIMER_PRESC_BITS-1:0] presc_q [`TIMER_CHANNELS];
    logic [`TIMER_BITS-1:0]       top_q   [`TIMER_CHANNELS];
    logic [`TIMER_BITS-1:0]       cmp_q   [`TIMER_CHANNELS];

    assign ch_field  = wb_req.adr[`WB_ADDR_BITS-1:OFS_BITS];
    assign ofs       = wb_req.adr[OFS_BITS-1:0];
    assign ch_hit    = (ch_field < `TIMER_CHANNELS);
    assign req_valid = wb_req.cyc && wb_req.stb && !ack_q && !hold_q;
    assign wr_en     = req_valid && wb_req.we;

    // classic handshake, one ack per strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            ack_q  <= req_valid;
            hold_q <= wb_req.stb && (hold_q || ack_q); // released once stb drops
        end
    end

    // channel registers, written on the ack edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            go_q      <= '0;
            rl_arm    <= '0;
            relatch_q <= '0;
            for (int c = 0; c < `TIMER_CHANNELS; c++) begin
                presc_q[c] <= '0;
                top_q[c]   <= '0;
                cmp_q[c]   <= '0;
            end
        end else begin
            relatch_q <= rl_arm; // delay so relatch lands after the ack
            rl_arm    <= '0;
            for (int c = 0; c < `TIMER_CHANNELS; c++) begin
                if (wr_en && ch_hit && (ch_field == c)) begin
                    case (ofs)
                        `REG_CTRL: go_q[c] <= wb_req.dat_w[0];
                        `REG_PRESC: begin
                            presc_q[c] <= wb_req.dat_w[`TIMER_PRESC_BITS-1:0];
                            rl_arm[c]  <= go_q[c];
                        end
                        `REG_TOP: begin
                            top_q[c]  <= wb_req.dat_w[`TIMER_BITS-1:0];
                            rl_arm[c] <= go_q[c];
                        end
                        `REG_CMP: begin
                            cmp_q[c]  <= wb_req.dat_w[`TIMER_BITS-1:0];
                            rl_arm[c] <= go_q[c];
                        end
                        default: ; // count is read only
                    endcase
                end
            end
        end
    end

    // read mux, unmapped reads give zero
    always_comb begin
        rd_data = '0;
        if (ch_hit) begin
            for (int c = 0; c < `TIMER_CHANNELS; c++) begin
                if (ch_field == c) begin
                    case (ofs)
                        `REG_CTRL:  rd_data[0] = go_q[c];
                        `REG_PRESC: rd_data[`TIMER_PRESC_BITS-1:0] = presc_q[c];
                        `REG_TOP:   rd_data[`TIMER_BITS-1:0] = top_q[c];
                        `REG_CMP:   rd_data[`TIMER_BITS-1:0] = cmp_q[c];
                        `REG_COUNT: rd_data[`TIMER_BITS-1:0] = stat[c].count;
                        default:    rd_data = '0;
                    endcase
                end
            end
        end else if (wb_req.adr == `REG_IRQ_STATUS) begin
            rd_data[`TIMER_CHANNELS-1:0] = irq_status;
        end else if (wb_req.adr == `REG_IRQ_ENABLE) begin
            rd_data[`TIMER_CHANNELS-1:0] = irq_enable;
        end
    end

    // read data captured with the ack
    always_ff @(posedge clk) begin
        if (req_valid && !wb_req.we) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    // per channel configuration out
    always_comb begin
        for (int c = 0; c < `TIMER_CHANNELS; c++) begin
            cfg[c].go      = go_q[c];
            cfg[c].relatch = relatch_q[c];
            cfg[c].presc   = presc_q[c];
            cfg[c].top     = top_q[c];
            cfg[c].cmp     = cmp_q[c];
        end
    end

    // interrupt strobes take effect on the ack edge
    assign irq_ctl.clr_mask = (wr_en && (wb_req.adr == `REG_IRQ_STATUS)) ?
                              wb_req.dat_w[`TIMER_CHANNELS-1:0] : '0;
    assign irq_ctl.en_we    = wr_en && (wb_req.adr == `REG_IRQ_ENABLE);
    assign irq_ctl.en_val   = wb_req.dat_w[`TIMER_CHANNELS-1:0];

endmodule

// File: design/timer_irq.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module timer_irq import timer_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`TIMER_CHANNELS-1:0] period_end, // straight from the channels
    input  irq_ctl_t                   ctl,
    output logic [`TIMER_CHANNELS-1:0] status,
    output logic [`TIMER_CHANNELS-1:0] enable,
    output logic                       irq
);

    logic [`TIMER_CHANNELS-1:0] pending; // enabled and set

    assign pending = status & enable;

    // sticky status, a set in the same cycle as a clear wins
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else begin
            status <= (status & ~ctl.clr_mask) | period_end;
        end
    end

    // enable mask
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            enable <= '0;
        end else if (ctl.en_we) begin
            enable <= ctl.en_val;
        end
    end

    // registered interrupt line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |pending;
        end
    end

endmodule

// File: design/timer_channel.sv
`timescale 1ns/1ps
`include "timer_defs.svh"

module timer_channel import timer_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  timer_cfg_t  cfg,
    output timer_stat_t stat
);

    // latched copies of the parameters
    logic [`TIMER_PRESC_BITS-1:0] presc_l;
    logic [`TIMER_BITS-1:0]       top_l;
    logic [`TIMER_BITS-1:0]       cmp_l;

    logic [`TIMER_PRESC_BITS-1:0] psc_cnt; // prescaler counter
    logic [`TIMER_BITS-1:0]       count;   // timer count
    logic                         go_l;    // latched go

    logic start;    // first cycle of go
    logic load;     // parameter load, start or relatch
    logic run;      // a counting cycle
    logic psc_term; // prescaler at terminal count

    assign start    = cfg.go && !go_l;
    assign load     = start || (go_l && cfg.go && cfg.relatch);
    assign run      = go_l && cfg.go && !cfg.relatch; // relatch holds the prescaler
    assign psc_term = (psc_cnt == presc_l); // latched value, not the live input

    // go, prescaler and count
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            go_l    <= 1'b0;
            psc_cnt <= '0;
            count   <= '0;
        end else if (start) begin
            go_l    <= 1'b1;
            psc_cnt <= '0; // restart from a clean period
            count   <= '0;
        end else if (go_l && !cfg.go) begin
            go_l <= 1'b0; // stop, count stays frozen
        end else if (run) begin
            if (psc_term) begin
                psc_cnt <= '0;
                // wrap at top
                if (count == top_l) begin
                    count <= '0;
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                psc_cnt <= psc_cnt + 1'b1;
            end
        end
    end

    // parameter latches, loaded on start and on relatch
    always_ff @(posedge clk) begin
        if (load) begin
            presc_l <= cfg.presc;
            top_l   <= cfg.top;
            cmp_l   <= cfg.cmp;
        end
    end

    assign stat.count      = count;
    assign stat.pwm        = go_l && (count <= cmp_l);  // cmp >= top keeps it high
    assign stat.period_end = run && psc_term && (count == top_l); // last tick before wrap

endmodule

// File: design/timer_pkg.sv
`include "timer_defs.svh"

package timer_pkg;

    // what one channel takes from the register file
    typedef struct packed {
        logic                         go;      // run the channel
        logic                         relatch; // one cycle, load new values on the fly
        logic [`TIMER_PRESC_BITS-1:0] presc;   // clock divided by presc+1
        logic [`TIMER_BITS-1:0]       top;     // count wraps after top
        logic [`TIMER_BITS-1:0]       cmp;     // pwm high while count <= cmp
    } timer_cfg_t;

    // what one channel reports back
    typedef struct packed {
        logic [`TIMER_BITS-1:0] count;      // raw count
        logic                   pwm;
        logic                   period_end; // pulse on the last tick of a period
    } timer_stat_t;

    // strobes from the register file into the interrupt block
    typedef struct packed {
        logic [`TIMER_CHANNELS-1:0] clr_mask; // write one to clear
        logic                       en_we;    // enable register write
        logic [`TIMER_CHANNELS-1:0] en_val;
    } irq_ctl_t;

endpackage

// File: design/wb_pkg.sv
`include "timer_defs.svh"

package wb_pkg;

    // master to slave, classic cycle
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`WB_ADDR_BITS-1:0]   adr;   // byte address
        logic [`WB_DATA_BITS-1:0]   dat_w;
        logic [`WB_DATA_BITS/8-1:0] sel;   // ignored by the slave, full word writes
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic                     ack;   // one cycle per transfer
        logic [`WB_DATA_BITS-1:0] dat_r; // valid with ack
    } wb_rsp_t;

endpackage

// File: design/timer_defs.svh
`ifndef TIMER_DEFS_SVH
`define TIMER_DEFS_SVH

// channel count and datapath widths
`define TIMER_CHANNELS   2
`define TIMER_PRESC_BITS 8
`define TIMER_BITS       16

// wishbone bus widths
`define WB_ADDR_BITS     8
`define WB_DATA_BITS     32

// each channel owns one block of this many bytes
`define TIMER_CH_STRIDE  'h20
`define REG_CTRL         'h00 // bit 0 is go
`define REG_PRESC        'h04
`define REG_TOP          'h08
`define REG_CMP          'h0C
`define REG_COUNT        'h10 // read only

// interrupt registers sit above the channel blocks
`define REG_IRQ_STATUS   'h80 // write one to clear
`define REG_IRQ_ENABLE   'h84
`endif
